// ==== filelist.f ====
logic/predecode_pkg.sv
logic/fetch_window.sv
logic/insn_length_decoder.sv
logic/insn_extractor.sv
logic/predecode_top.sv
testbench/predecode_checker.sv
testbench/tb_predecode.sv

// ==== logic/fetch_window.sv ====
// Fetch window that reads 64-bit code words over Wishbone classic and keeps twelve parcels
`timescale 1ns/1ns

module fetch_window #(
  parameter logic [31:0] RESET_ADDR = 32'h0000_1000
) (
  input  logic                          clk,
  input  logic                          reset,
  output predecode_pkg::wb_req_t        wb_req,
  input  logic [63:0]                   wb_dat,
  input  logic                          wb_ack,
  input  logic [3:0]                    consume,
  output predecode_pkg::parcel_t [11:0] window,
  output logic [3:0]                    fill,
  output logic [31:0]                   window_pc
);
  import predecode_pkg::*;

  localparam int WIN_PARCELS  = 12;
  localparam int WORD_PARCELS = 4;

  // ==============================
  // State
  // ==============================

  // Window contents, parcel 0 is the oldest not yet issued
  parcel_t [WIN_PARCELS-1:0]  win_q;
  parcel_t [WIN_PARCELS-1:0]  win_d;
  // The acked bus word split into its four parcels, parcel 0 in the low bits
  parcel_t [WORD_PARCELS-1:0] word_parcels;
  // Number of parcels in the window that hold fetched code
  logic [3:0]                 fill_q;
  logic [3:0]                 fill_shifted;
  // Byte address of window parcel 0
  logic [31:0]                pc_q;
  // Word address of the next read, one word is 8 bytes
  logic [31:0]                fetch_word_q;
  // Single-beat bus cycle in flight
  logic                       cyc_q;
  logic                       take_word;

  // A word is only taken while our own cycle is open
  assign take_word    = cyc_q && wb_ack;
  assign word_parcels = wb_dat;
  // Fill count after the extractor has removed its parcels
  assign fill_shifted = fill_q - consume;

  // ==============================
  // Shift and append
  // ==============================

  // Shift down by consume first, then drop an acked word in right behind the remaining parcels
  always_comb begin
    int src;
    int slot;
    for (int i = 0; i < WIN_PARCELS; i++) begin
      src  = i + int'(consume);
      slot = i - int'(fill_shifted);
      if (src < WIN_PARCELS) begin
        win_d[i] = win_q[src];
      end else begin
        win_d[i] = '0;
      end
      // Parcels of a new word land at fill_shifted and up
      if (take_word && slot >= 0 && slot < WORD_PARCELS) begin
        win_d[i] = word_parcels[slot];
      end
    end
  end

  // Window parcels reload on every edge from the shift and append logic
  always_ff @(posedge clk) begin
    win_q <= win_d;
  end

  // ==============================
  // Control and bus state
  // ==============================

  always_ff @(posedge clk) begin
    if (reset) begin
      cyc_q        <= 1'b0;
      fill_q       <= 4'd0;
      pc_q         <= RESET_ADDR;
      fetch_word_q <= {3'b000, RESET_ADDR[31:3]};
    end else begin
      fill_q <= fill_shifted + (take_word ? 4'd4 : 4'd0);
      // Each consumed parcel advances the window pc by two bytes
      pc_q   <= pc_q + {27'd0, consume, 1'b0};
      if (take_word) begin
        // Close the cycle on ack and move on to the next sequential word
        cyc_q        <= 1'b0;
        fetch_word_q <= fetch_word_q + 32'd1;
      end else if (!cyc_q && fill_q <= 4'd8) begin
        // Room for a whole word, since fill can only shrink while we wait
        cyc_q <= 1'b1;
      end
    end
  end

  // cyc and stb move together, adr is held until the ack
  assign wb_req.cyc = cyc_q;
  assign wb_req.stb = cyc_q;
  assign wb_req.adr = fetch_word_q;

  assign window    = win_q;
  assign fill      = fill_q;
  assign window_pc = pc_q;

endmodule

// ==== logic/insn_extractor.sv ====
// Instruction extractor that issues up to two complete instructions from the parcel window
`timescale 1ns/1ns

module insn_extractor #(
  parameter int NUM_DECODERS = 4
) (
  input  predecode_pkg::parcel_t [11:0]              window,
  input  logic [3:0]                                 fill,
  input  logic [31:0]                                window_pc,
  input  predecode_pkg::ins_len_t [NUM_DECODERS-1:0] lens,
  input  logic                                       out_ready,
  output predecode_pkg::insn_out_t [1:0]             out_slot,
  output logic [3:0]                                 consume
);
  import predecode_pkg::*;

  // ==============================
  // Lengths and validity
  // ==============================

  // Length of the instruction at parcel 0
  ins_len_t      len0;
  // Length of the instruction right after it
  ins_len_t      len1;
  // Parcels spanned by both instructions together
  logic [3:0]    end1;
  // Set when a decoder looks at the parcel where slot 1 starts
  logic          has_dec1;
  logic          valid0;
  logic          valid1;
  // Candidate parcels of each slot before masking
  parcel_t [3:0] raw0;
  parcel_t [3:0] raw1;
  // Parcels each valid slot removes from the window
  logic [3:0]    take0;
  logic [3:0]    take1;

  assign len0 = lens[0];

  // Slot 1 starts at parcel len0, so its length comes from decoder len0
  always_comb begin
    len1     = 3'd1;
    has_dec1 = 1'b0;
    for (int k = 1; k < NUM_DECODERS; k++) begin
      if (int'(len0) == k) begin
        len1     = lens[k];
        has_dec1 = 1'b1;
      end
    end
  end

  assign end1 = {1'b0, len0} + {1'b0, len1};

  // Slot 0 issues once every parcel of its instruction is in the window
  assign valid0 = ({1'b0, len0} <= fill);
  // A four parcel first instruction leaves slot 1 empty, no decoder covers parcel 4
  assign valid1 = valid0 && has_dec1 && (end1 <= fill);

  // ==============================
  // Instruction assembly
  // ==============================

  assign raw0 = window[3:0];

  // Gather the four parcels that follow the first instruction
  always_comb begin
    for (int j = 0; j < 4; j++) begin
      raw1[j] = window[{1'b0, len0} + 4'(j)];
    end
  end

  always_comb begin
    // Slot 0 is always the instruction at the head of the window
    out_slot[0].valid    = valid0;
    out_slot[0].pc       = window_pc;
    out_slot[0].len      = len0;
    out_slot[0].insn.raw = raw0 & len_mask(len0);

    // Slot 1 sits two bytes per parcel past slot 0
    out_slot[1].valid    = valid1;
    out_slot[1].pc       = window_pc + {28'd0, len0, 1'b0};
    out_slot[1].len      = len1;
    out_slot[1].insn.raw = raw1 & len_mask(len1);
  end

  // ==============================
  // Window consumption
  // ==============================

  assign take0 = valid0 ? {1'b0, len0} : 4'd0;
  assign take1 = valid1 ? {1'b0, len1} : 4'd0;

  // Everything valid goes when the consumer is ready, else the window holds
  assign consume = out_ready ? (take0 + take1) : 4'd0;

endmodule

// ==== logic/insn_length_decoder.sv ====
// Length decoder that maps one opcode to the instruction size in parcels
`timescale 1ns/1ns

module insn_length_decoder (
  input  predecode_pkg::opcode_t  opcode,
  output predecode_pkg::ins_len_t len
);
  import predecode_pkg::*;

  // ==============================
  // Opcode length table
  // ==============================

  // Wildcard rows only cover whole nibble ranges, no listed opcode falls inside them
  always_comb begin
    casez (opcode)
      // Single parcel forms
      BRK:          len = 3'd1;
      NOP:          len = 3'd1;
      RTS:          len = 3'd1;
      // Short constant extension fits in the first parcel
      EXI8:         len = 3'd1;
      EXI8 + 8'd1:  len = 3'd1;

      // Register forms
      R1:           len = 3'd2;
      R2:           len = 3'd3;

      // Immediate arithmetic, the L forms carry a long immediate
      ADDI:         len = 3'd2;
      ADDIL:        len = 3'd3;
      ANDI:         len = 3'd2;
      ANDIL:        len = 3'd3;

      // Constant extension prefixes grow by one parcel per 16 bits
      EXI24:        len = 3'd2;
      EXI24 + 8'd1: len = 3'd2;
      EXI40:        len = 3'd3;
      EXI40 + 8'd1: len = 3'd3;
      EXI56:        len = 3'd4;
      EXI56 + 8'd1: len = 3'd4;
      EXIM:         len = 3'd4;

      // Loads and stores, displacement forms are longer than indexed forms
      LDO:          len = 3'd3;
      LDOX:         len = 3'd2;
      STO:          len = 3'd3;
      STOX:         len = 3'd2;

      // Stack frame setup
      ENTER:        len = 3'd2;

      // Branches
      8'h2?:        len = 3'd3;
      // Decrement and branch
      8'h3?:        len = 3'd3;
      // Remaining three parcel groups
      8'hD?:        len = 3'd3;
      8'hE?:        len = 3'd3;

      // Anything not in the table takes a single parcel
      default:      len = 3'd1;
    endcase
  end

endmodule

// ==== logic/predecode_pkg.sv ====
// Predecode package holding parcel and instruction types, opcode constants and a length mask helper
package predecode_pkg;

  // ==============================
  // Basic types
  // ==============================

  // One 16-bit instruction parcel, the unit of instruction length
  typedef logic [15:0] parcel_t;

  // The opcode lives in the low byte of the first parcel
  typedef logic [7:0] opcode_t;

  // Instruction length counted in parcels, legal values are 1 to 4
  typedef logic [2:0] ins_len_t;

  // ==============================
  // Opcodes
  // ==============================

  // Representative subset of the full opcode map
  localparam opcode_t BRK   = 8'h00;
  localparam opcode_t R1    = 8'h01;
  localparam opcode_t R2    = 8'h02;
  localparam opcode_t ADDI  = 8'h04;
  localparam opcode_t ADDIL = 8'h05;
  localparam opcode_t ANDI  = 8'h08;
  localparam opcode_t ANDIL = 8'h09;
  localparam opcode_t EXI8  = 8'h50;
  localparam opcode_t EXI24 = 8'h52;
  localparam opcode_t EXI40 = 8'h54;
  localparam opcode_t EXI56 = 8'h56;
  localparam opcode_t EXIM  = 8'h58;
  localparam opcode_t LDO   = 8'h80;
  localparam opcode_t LDOX  = 8'h81;
  localparam opcode_t STO   = 8'h90;
  localparam opcode_t STOX  = 8'h91;
  localparam opcode_t NOP   = 8'hF1;
  localparam opcode_t RTS   = 8'hF2;
  localparam opcode_t ENTER = 8'hF4;

  // ==============================
  // Instruction containers
  // ==============================

  // Field view of an instruction word, operands sit above the opcode byte
  typedef struct packed {
    logic [55:0] operand;
    opcode_t     opcode;
  } insn_fields_t;

  // The same 64 bits seen either as four parcels or as opcode plus operands
  typedef union packed {
    parcel_t [3:0] raw;
    insn_fields_t  fields;
  } insn_u;

  // One issue slot toward the consumer, pc is a byte address
  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    ins_len_t    len;
    insn_u       insn;
  } insn_out_t;

  // Wishbone classic read request, adr counts 64-bit words
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic [31:0] adr;
  } wb_req_t;

  // Bit mask that keeps the first len parcels of a 64-bit instruction word
  function automatic logic [63:0] len_mask(ins_len_t len);
    logic [63:0] mask;
    mask = '0;
    for (int i = 0; i < 4; i++) begin
      if (i < int'(len)) begin
        mask[i*16 +: 16] = 16'hFFFF;
      end
    end
    return mask;
  endfunction

endpackage

// ==== logic/predecode_top.sv ====
// Predecode front end top joining the fetch window, the length decoders and the extractor
`timescale 1ns/1ns

module predecode_top #(
  parameter logic [31:0] RESET_ADDR   = 32'h0000_1000,
  parameter int          NUM_DECODERS = 4
) (
  input  logic                           clk,
  input  logic                           reset,
  output predecode_pkg::wb_req_t         wb_req,
  input  logic [63:0]                    wb_dat,
  input  logic                           wb_ack,
  output predecode_pkg::insn_out_t [1:0] out_slot,
  input  logic                           out_ready
);
  import predecode_pkg::*;

  // Window state shared by the decoders and the extractor
  parcel_t [11:0]              window;
  logic [3:0]                  fill;
  logic [31:0]                 window_pc;
  logic [3:0]                  consume;
  // One length per decoded window parcel
  ins_len_t [NUM_DECODERS-1:0] lens;

  fetch_window #(
    .RESET_ADDR(RESET_ADDR)
  ) u_fetch_window (
    .clk      (clk),
    .reset    (reset),
    .wb_req   (wb_req),
    .wb_dat   (wb_dat),
    .wb_ack   (wb_ack),
    .consume  (consume),
    .window   (window),
    .fill     (fill),
    .window_pc(window_pc)
  );

  // ==============================
  // Length decoders
  // ==============================

  // Decoder k treats parcel k as a possible instruction start
  for (genvar k = 0; k < NUM_DECODERS; k++) begin : g_dec
    insn_u view;
    assign view.raw = window[k+3:k];
    insn_length_decoder u_len (
      .opcode(view.fields.opcode),
      .len   (lens[k])
    );
  end

  insn_extractor #(
    .NUM_DECODERS(NUM_DECODERS)
  ) u_extractor (
    .window   (window),
    .fill     (fill),
    .window_pc(window_pc),
    .lens     (lens),
    .out_ready(out_ready),
    .out_slot (out_slot),
    .consume  (consume)
  );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build the predecode testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  -f filelist.f \
  --top-module tb_predecode \
  -o tb_predecode

./obj_dir/tb_predecode 2>&1 | tee sim.log

if grep -q "Simulation passed" sim.log; then
  exit 0
else
  exit 1
fi

// ==== testbench/predecode_checker.sv ====
// Checker for the predecode front end covering the Wishbone read protocol and the issue slots
`timescale 1ns/1ns

module predecode_checker (
  input logic                           clk,
  input logic                           reset,
  input predecode_pkg::wb_req_t         wb_req,
  input logic                           wb_ack,
  input predecode_pkg::insn_out_t [1:0] out_slot
);
  import predecode_pkg::*;

  // ==============================
  // Wishbone classic
  // ==============================

  // A strobe is only legal inside an open bus cycle
  a_stb_in_cyc: assert property (@(posedge clk) disable iff (reset)
    wb_req.stb |-> wb_req.cyc)
    else $error("Wishbone stb is high while cyc is low");

  // Until the slave acks, the request stays up with the same word address
  a_adr_stable: assert property (@(posedge clk) disable iff (reset)
    (wb_req.stb && !wb_ack) |=> (wb_req.stb && $stable(wb_req.adr)))
    else $error("Wishbone request dropped or adr changed before ack");

  // ==============================
  // Issue slots
  // ==============================

  // Slot 1 never runs ahead of slot 0
  a_slot_order: assert property (@(posedge clk) disable iff (reset)
    out_slot[1].valid |-> out_slot[0].valid)
    else $error("Slot 1 valid while slot 0 is not valid");

  // Once reset has taken hold, nothing is issued
  a_reset_quiet: assert property (@(posedge clk)
    (reset && $past(reset)) |-> (!out_slot[0].valid && !out_slot[1].valid))
    else $error("Issue slot valid during reset");

endmodule

bind predecode_top predecode_checker u_checker (
  .clk     (clk),
  .reset   (reset),
  .wb_req  (wb_req),
  .wb_ack  (wb_ack),
  .out_slot(out_slot)
);

// ==== testbench/tb_predecode.sv ====
// Testbench for the predecode front end with a Wishbone memory model and a reference walk
`timescale 1ns/1ns

module tb_predecode;
  import predecode_pkg::*;

  localparam logic [31:0] RESET_ADDR = 32'h0000_1000;
  localparam int MEM_PARCELS = 512;
  // Every parcel of the stream gets twenty cycles on average to come out
  localparam int TIMEOUT_CYCLES = 20 * MEM_PARCELS;

  logic            clk;
  logic            reset;
  wb_req_t         wb_req;
  logic [63:0]     wb_dat;
  logic            wb_ack;
  insn_out_t [1:0] out_slot;
  logic            out_ready;

  // Code image starting at RESET_ADDR, and the instructions still to be seen
  parcel_t   mem [MEM_PARCELS];
  insn_out_t exp_q [$];
  opcode_t   pool [23];
  int        errors;
  int        checks;
  int        cycles;
  int        reset_cycles;
  int        wait_left;
  logic      busy;

  predecode_top #(
    .RESET_ADDR  (RESET_ADDR),
    .NUM_DECODERS(4)
  ) dut0 (
    .clk      (clk),
    .reset    (reset),
    .wb_req   (wb_req),
    .wb_dat   (wb_dat),
    .wb_ack   (wb_ack),
    .out_slot (out_slot),
    .out_ready(out_ready)
  );

  always #10 clk = ~clk;

  // ==============================
  // Reference model
  // ==============================

  // Length in parcels straight from the opcode table
  function automatic ins_len_t expected_len(opcode_t op);
    if (op inside {R1, ADDI, ANDI, LDOX, STOX, EXI24, EXI24 + 8'd1, ENTER}) begin
      return 3'd2;
    end
    if (op inside {R2, ADDIL, ANDIL, LDO, STO, EXI40, EXI40 + 8'd1}) begin
      return 3'd3;
    end
    // Whole nibble groups 2x, 3x, Dx and Ex
    if (op[7:4] inside {4'h2, 4'h3, 4'hD, 4'hE}) begin
      return 3'd3;
    end
    if (op inside {EXI56, EXI56 + 8'd1, EXIM}) begin
      return 3'd4;
    end
    return 3'd1;
  endfunction

  // Random stream of table opcodes, wildcard groups and unlisted bytes
  task automatic build_stream();
    int       pos;
    int       r;
    opcode_t  op;
    ins_len_t len;
    pool = '{BRK, R1, R2, ADDI, ADDIL, ANDI, ANDIL, LDO, LDOX, STO, STOX, EXI8, EXI8 + 8'd1,
             EXI24, EXI24 + 8'd1, EXI40, EXI40 + 8'd1, EXI56, EXI56 + 8'd1, EXIM, NOP, RTS,
             ENTER};
    pos = 0;
    while (pos < MEM_PARCELS) begin
      r = int'($urandom % 26);
      if (r < 23) begin
        op = pool[r];
      end else if (r == 23) begin
        op = {4'h2, 4'($urandom)};
      end else if (r == 24) begin
        op = {4'hD, 4'($urandom)};
      end else begin
        op = 8'($urandom);
      end
      len = expected_len(op);
      // The tail is padded with single parcel instructions
      if (pos + int'(len) > MEM_PARCELS) begin
        op  = NOP;
        len = 3'd1;
      end
      mem[pos] = {8'($urandom), op};
      for (int i = 1; i < int'(len); i++) begin
        mem[pos + i] = 16'($urandom);
      end
      pos += int'(len);
    end
  endtask

  // Walk the image and record pc, length and masked bits of each instruction
  task automatic build_expected();
    int        pos;
    insn_out_t e;
    pos = 0;
    while (pos < MEM_PARCELS) begin
      e             = '0;
      e.valid       = 1'b1;
      e.pc          = RESET_ADDR + 32'(2 * pos);
      e.insn.raw[0] = mem[pos];
      e.len         = expected_len(e.insn.fields.opcode);
      for (int i = 1; i < int'(e.len); i++) begin
        e.insn.raw[i] = mem[pos + i];
      end
      exp_q.push_back(e);
      pos += int'(e.len);
    end
  endtask

  // ==============================
  // Memory model and stimulus
  // ==============================

  // Word address to four parcels, anything outside the image reads as zero
  function automatic logic [63:0] read_word(logic [31:0] adr);
    logic [63:0] word;
    int          base;
    word = '0;
    base = int'(adr) * 4 - int'(RESET_ADDR >> 1);
    for (int i = 0; i < 4; i++) begin
      if (base + i >= 0 && base + i < MEM_PARCELS) begin
        word[i*16 +: 16] = mem[base + i];
      end
    end
    return word;
  endfunction

  always @(negedge clk) begin
    if (reset_cycles > 0) begin
      reset_cycles--;
      if (reset_cycles == 0) begin
        reset = 1'b0;
      end
    end else begin
      // Consumer is ready about seven cycles out of ten
      out_ready = ($urandom % 10) < 7;
      if (wb_ack) begin
        // The word went in on the rising edge and the master closed its cycle
        wb_ack = 1'b0;
      end else if (wb_req.cyc && wb_req.stb) begin
        if (!busy) begin
          busy      = 1'b1;
          wait_left = int'($urandom % 4);
        end
        if (wait_left == 0) begin
          wb_dat = read_word(wb_req.adr);
          wb_ack = 1'b1;
          busy   = 1'b0;
        end else begin
          wait_left--;
        end
      end
    end
  end

  // ==============================
  // Checking
  // ==============================

  task automatic check_len(ins_len_t got, ins_len_t exp, string name);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED time %0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_insn(insn_out_t got, insn_out_t exp, string name);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED time %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // The length must follow the table, the whole slot must be the next one in the stream
  task automatic compare_slot(insn_out_t got, string name);
    check_len(got.len, expected_len(got.insn.fields.opcode), {name, ".len"});
    check_insn(got, exp_q.pop_front(), name);
  endtask

  // Slots seen on a ready edge are the ones handed over, slot 0 first
  always @(posedge clk) begin
    if (!reset && out_ready) begin
      if (out_slot[0].valid && exp_q.size() > 0) begin
        compare_slot(out_slot[0], "out_slot[0]");
      end
      if (out_slot[1].valid && exp_q.size() > 0) begin
        compare_slot(out_slot[1], "out_slot[1]");
      end
    end
  end

  initial begin
    void'($urandom(7));
    clk          = 1'b0;
    reset        = 1'b1;
    reset_cycles = 16;
    wb_dat       = '0;
    wb_ack       = 1'b0;
    out_ready    = 1'b0;
    errors       = 0;
    checks       = 0;
    busy         = 1'b0;
    wait_left    = 0;
    build_stream();
    build_expected();
    wait (reset == 1'b0);
    if (out_slot[0].valid || out_slot[1].valid || wb_req.cyc) begin
      errors++;
      $display("An issue slot or the bus cycle was active right after reset");
    end
    cycles = 0;
    while (exp_q.size() > 0 && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    if (exp_q.size() > 0) begin
      errors++;
      $display("Timeout after %0d cycles with %0d instructions not yet issued",
               cycles, exp_q.size());
    end
    $display("Checks %0d, errors %0d, cycles %0d", checks, errors, cycles);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
